// File: hw/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

  // payload bits carried by one frame
  localparam int unsigned data_bits = 8;

  // start + data + parity + stop
  localparam int unsigned frame_bits = 11;

  // receive side parity handling
  typedef enum logic {
    no_check  = 1'b0,
    odd_check = 1'b1
  } parity_mode_e;

endpackage

`default_nettype wire

// File: hw/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  localparam int unsigned cmd_width = 16;

  // command word layout
  localparam int unsigned rw_bit   = 15;
  localparam int unsigned addr_msb = 14;
  localparam int unsigned addr_lsb = 8;

  // matches the encoding of rw_bit
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } op_e;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    send_data,
    wait_resp,
    done
  } seq_state_e;

endpackage

`default_nettype wire

// File: hw/uart_tx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame #(
  parameter int unsigned CLKS_PER_BIT = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 tx_start,
  input  logic [uart_frame_pkg::data_bits-1:0] tx_byte,
  output logic                                 tx,
  output logic                                 tx_busy,
  output logic                                 tx_done
);

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int unsigned BIT_W = $clog2(uart_frame_pkg::frame_bits);
  localparam int unsigned SR_W  = uart_frame_pkg::frame_bits - 1;
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_W-1:0] STOP_IDX  = BIT_W'(uart_frame_pkg::frame_bits - 1);

  logic [CNT_W-1:0] cnt;
  logic [BIT_W-1:0] bit_idx;
  // data, parity and stop still to go out, lsb first
  logic [SR_W-1:0]  sr;
  logic             bit_end;

  assign bit_end = tx_busy && (cnt == BAUD_LAST);

  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_idx == STOP_IDX);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end else if (bit_end) begin
      cnt <= '0;
      if (bit_idx == STOP_IDX) begin
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end else begin
        tx      <= sr[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      // odd parity is the inverted xor of the byte
      sr <= {1'b1, ~^tx_byte, tx_byte};
    end else if (bit_end) begin
      sr <= {1'b1, sr[SR_W-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_rx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame #(
  parameter int unsigned                  CLKS_PER_BIT = 434,
  parameter uart_frame_pkg::parity_mode_e CHECK_PARITY = uart_frame_pkg::odd_check
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rx,
  input  logic                                 rx_arm,
  output logic                                 rx_busy,
  output logic                                 rx_valid,
  output logic [uart_frame_pkg::data_bits-1:0] rx_byte,
  output logic                                 rx_parity_err
);

  localparam int unsigned DATA_W = uart_frame_pkg::data_bits;
  localparam int unsigned CNT_W  = $clog2(CLKS_PER_BIT + 1);
  localparam int unsigned BIT_W  = $clog2(uart_frame_pkg::frame_bits);
  localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [BIT_W-1:0] LAST_DATA = BIT_W'(DATA_W);
  localparam logic [BIT_W-1:0] PAR_IDX   = BIT_W'(DATA_W + 1);
  localparam logic [BIT_W-1:0] STOP_IDX  = BIT_W'(uart_frame_pkg::frame_bits - 1);

  logic              rx_s1;
  logic              rx_s2;
  logic              rx_prev;
  logic              start_edge;
  logic              sample;
  logic              parity_bad;
  logic [CNT_W-1:0]  cnt;
  logic [BIT_W-1:0]  bit_idx;
  logic [DATA_W-1:0] data_sr;
  logic              par_bit;

  // idle high so reset does not look like a start edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign start_edge = rx_prev && !rx_s2;
  assign sample     = rx_busy && (cnt == '0);
  assign parity_bad = (CHECK_PARITY == uart_frame_pkg::odd_check) && (par_bit != ~^data_sr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
      cnt      <= '0;
      bit_idx  <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!rx_busy) begin
        if (start_edge && rx_arm) begin
          rx_busy <= 1'b1;
          cnt     <= HALF_LOAD;
          bit_idx <= '0;
        end
      end else if (!sample) begin
        cnt <= cnt - 1'b1;
      end else begin
        cnt     <= FULL_LOAD;
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_s2) begin
          // start bit already gone by mid-bit
          rx_busy <= 1'b0;
        end else if (bit_idx == STOP_IDX) begin
          rx_busy  <= 1'b0;
          rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx != '0 && bit_idx <= LAST_DATA) begin
        data_sr <= {rx_s2, data_sr[DATA_W-1:1]};
      end
      if (bit_idx == PAR_IDX) begin
        par_bit <= rx_s2;
      end
      if (bit_idx == STOP_IDX) begin
        rx_byte       <= data_sr;
        // framing error folds into the same flag
        rx_parity_err <= parity_bad || !rx_s2;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_seq #(
  parameter int unsigned CLKS_PER_BIT      = 434,
  parameter int unsigned RESP_TIMEOUT_BITS = 32,
  parameter int unsigned READ_WIDTH        = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic                               tx_start,
  output logic [7:0]                         tx_byte,
  input  logic                               tx_busy,
  input  logic                               tx_done,
  output logic                               rx_arm,
  input  logic                               rx_busy,
  input  logic                               rx_valid,
  input  logic [7:0]                         rx_byte,
  input  logic                               rx_parity_err,
  output logic                               read_rdy,
  output logic [READ_WIDTH:0]                read_data
);

  localparam int unsigned ADDR_W = uart_cmd_pkg::addr_msb - uart_cmd_pkg::addr_lsb + 1;
  localparam int unsigned TIMEOUT_CYCLES = RESP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int unsigned TO_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [TO_W-1:0] TO_LAST = TO_W'(TIMEOUT_CYCLES - 1);

  uart_cmd_pkg::seq_state_e state;
  uart_cmd_pkg::op_e        op_q;

  logic [ADDR_W-1:0] addr_q;
  logic [7:0]        data_q;
  logic              accept;
  logic              launched;
  logic [TO_W-1:0]   to_cnt;
  logic              timed_out;

  assign accept    = cmd_vld && cmd_rdy;
  assign rx_arm    = (state == uart_cmd_pkg::wait_resp);
  assign timed_out = rx_arm && !rx_busy && (to_cnt == TO_LAST);

  // address byte carries the op in bit 7
  assign tx_byte = (state == uart_cmd_pkg::send_data) ? data_q
                 : {(op_q == uart_cmd_pkg::op_read), addr_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q   <= uart_cmd_pkg::op_e'(cmd_in[uart_cmd_pkg::rw_bit]);
      addr_q <= cmd_in[uart_cmd_pkg::addr_msb:uart_cmd_pkg::addr_lsb];
      data_q <= cmd_in[7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_cmd_pkg::idle;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      launched <= 1'b0;
      read_rdy <= 1'b0;
      to_cnt   <= '0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        uart_cmd_pkg::idle, uart_cmd_pkg::done: begin
          if (accept) begin
            cmd_rdy <= 1'b0;
            state   <= uart_cmd_pkg::send_addr;
          end else begin
            state <= uart_cmd_pkg::idle;
          end
        end
        uart_cmd_pkg::send_addr, uart_cmd_pkg::send_data: begin
          if (!launched && !tx_busy) begin
            tx_start <= 1'b1;
            launched <= 1'b1;
          end
          if (tx_done) begin
            launched <= 1'b0;
            if (state == uart_cmd_pkg::send_data) begin
              cmd_rdy <= 1'b1;
              state   <= uart_cmd_pkg::done;
            end else if (op_q == uart_cmd_pkg::op_write) begin
              state <= uart_cmd_pkg::send_data;
            end else begin
              to_cnt <= '0;
              state  <= uart_cmd_pkg::wait_resp;
            end
          end
        end
        uart_cmd_pkg::wait_resp: begin
          if (rx_valid || timed_out) begin
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= uart_cmd_pkg::done;
          end else if (!rx_busy) begin
            // held while a frame arrives and resumed after a false start
            to_cnt <= to_cnt + 1'b1;
          end
        end
        default: begin
          state <= uart_cmd_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_arm && rx_valid) begin
      read_data <= {rx_parity_err, READ_WIDTH'(rx_byte)};
    end else if (timed_out) begin
      read_data <= {1'b1, {READ_WIDTH{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge #(
  parameter int unsigned                  CLKS_PER_BIT      = 434,
  parameter uart_frame_pkg::parity_mode_e CHECK_PARITY      = uart_frame_pkg::odd_check,
  parameter int unsigned                  RESP_TIMEOUT_BITS = 32,
  parameter int unsigned                  READ_WIDTH        = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  input  logic                               rx,
  output logic                               tx,
  output logic                               read_rdy,
  output logic [READ_WIDTH:0]                read_data
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       tx_done;
  logic       rx_arm;
  logic       rx_busy;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       rx_parity_err;

  uart_cmd_seq #(
    .CLKS_PER_BIT      (CLKS_PER_BIT),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS),
    .READ_WIDTH        (READ_WIDTH)
  ) u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .rx_arm        (rx_arm),
    .rx_busy       (rx_busy),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .read_rdy      (read_rdy),
    .read_data     (read_data)
  );

  uart_tx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .CHECK_PARITY (CHECK_PARITY)
  ) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_arm        (rx_arm),
    .rx_busy       (rx_busy),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // release between active edges
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int unsigned CLKS_PER_BIT = 8,
  parameter int unsigned READ_WIDTH   = 8
) (
  input logic                clk,
  input logic                rst_n,
  input logic                cmd_vld,
  input logic                cmd_rdy,
  input logic                tx,
  input logic                read_rdy,
  input logic [READ_WIDTH:0] read_data
);

  localparam int unsigned HALF = CLKS_PER_BIT / 2;

  int unsigned         errors  = 0;
  int unsigned         frames  = 0;
  int unsigned         reads   = 0;
  int unsigned         accepts = 0;
  int unsigned         phase   = 0;
  int unsigned         bit_k;
  logic                live     = 1'b0;
  logic                prev_rdy = 1'b0;
  logic [10:0]         frame;
  logic [7:0]          exp_frames[$];
  logic [READ_WIDTH:0] exp_reads[$];
  logic [READ_WIDTH:0] exp_read;

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, sig, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic expect_frame(input logic [7:0] b);
    exp_frames.push_back(b);
  endtask

  task automatic expect_read(input logic [READ_WIDTH:0] r);
    exp_reads.push_back(r);
  endtask

  task automatic check_frame(input logic [10:0] f);
    logic [7:0] exp_b;
    frames++;
    if (f[0] !== 1'b0) report_mismatch("tx start bit", 0, f[0]);
    if (f[9] !== ~^f[8:1]) report_mismatch("tx parity bit", ~^f[8:1], f[9]);
    if (f[10] !== 1'b1) report_mismatch("tx stop bit", 1, f[10]);
    if (exp_frames.size() == 0) begin
      report_failure("a frame appeared on tx that no accepted command calls for");
    end else begin
      exp_b = exp_frames.pop_front();
      if (f[8:1] !== exp_b) report_mismatch("tx frame byte", exp_b, f[8:1]);
    end
  endtask

  task automatic check_read();
    if (prev_rdy === 1'b1) begin
      report_failure("read_rdy stayed high for more than one cycle");
    end else if (exp_reads.size() == 0) begin
      report_failure("read_rdy pulsed with no read outstanding");
    end else begin
      exp_read = exp_reads.pop_front();
      reads++;
      if (read_data !== exp_read) report_mismatch("read_data", exp_read, read_data);
    end
  endtask

  task automatic final_check(input int unsigned issued);
    if (accepts != issued) begin
      report_failure($sformatf("%0d commands accepted, %0d issued", accepts, issued));
    end
    if (exp_frames.size() != 0) report_failure("fewer frames on tx than commands call for");
    if (exp_reads.size() != 0) report_failure("a read ended without a read_rdy pulse");
  endtask

  // handshake seen on the active edge before the DUT updates
  always @(posedge clk) begin
    if (!live && rst_n === 1'b1) begin
      live = 1'b1;
      if (cmd_rdy !== 1'b1) report_mismatch("cmd_rdy", 1, cmd_rdy);
      if (tx !== 1'b1) report_mismatch("tx", 1, tx);
      if (read_rdy !== 1'b0) report_mismatch("read_rdy", 0, read_rdy);
    end
    if (live && cmd_vld === 1'b1 && cmd_rdy === 1'b1) accepts++;
  end

  // phase counts falling edges since the tx start bit began
  always @(negedge clk) begin
    if (live) begin
      if (phase != 0 || tx === 1'b0) phase++;
      if (phase >= HALF && (phase - HALF) % CLKS_PER_BIT == 0) begin
        bit_k = (phase - HALF) / CLKS_PER_BIT;
        frame[bit_k] = tx;
        if (bit_k == uart_frame_pkg::frame_bits - 1) begin
          check_frame(frame);
          phase = 0;
        end
      end
      if (read_rdy === 1'b1) check_read();
      prev_rdy = read_rdy;
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int unsigned CLKS_PER_BIT      = 8;
  localparam int unsigned RESP_TIMEOUT_BITS = 32;
  localparam int unsigned READ_WIDTH        = 8;
  localparam int unsigned NUM_CMDS          = 40;
  // longer than any command including silent reads
  localparam int unsigned WAIT_LIMIT =
    (2 * uart_frame_pkg::frame_bits + RESP_TIMEOUT_BITS + 8) * CLKS_PER_BIT;

  logic                               clk;
  logic                               rst_n;
  logic [uart_cmd_pkg::cmd_width-1:0] cmd_in;
  logic                               cmd_vld;
  logic                               cmd_rdy;
  logic                               rx;
  logic                               tx;
  logic                               read_rdy;
  logic [READ_WIDTH:0]                read_data;

  // register file of the remote device
  logic [7:0]  regs [128];
  integer      seed;
  integer      r;
  int unsigned timeouts;
  int unsigned idx;
  logic [15:0] cmd;

  tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) clk_gen (.*);

  uart_cmd_bridge #(
    .CLKS_PER_BIT      (CLKS_PER_BIT),
    .CHECK_PARITY      (uart_frame_pkg::odd_check),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS),
    .READ_WIDTH        (READ_WIDTH)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  tb_checker #(.CLKS_PER_BIT(CLKS_PER_BIT), .READ_WIDTH(READ_WIDTH)) chk (.*);

  task automatic wait_cmd_rdy();
    int unsigned cnt;
    cnt = 0;
    while (cmd_rdy !== 1'b1 && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (cmd_rdy !== 1'b1) begin
      $display("Timeout at %0t: cmd_rdy never came back high", $time);
      timeouts++;
    end
  endtask

  // remote side receiver sampling tx near mid-bit
  task automatic recv_frame(output logic [7:0] b, output logic ok);
    int unsigned cnt;
    cnt = 0;
    ok  = 1'b0;
    b   = '0;
    @(negedge clk);
    while (tx !== 1'b0 && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (tx !== 1'b0) begin
      $display("Timeout at %0t: no frame started on tx", $time);
      timeouts++;
    end else begin
      ok = 1'b1;
      repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
      for (int k = 0; k < 8; k++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[k] = tx;
      end
      // on through parity to the middle of the stop bit
      repeat (2 * CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_parity);
    logic [10:0] f;
    f = {1'b1, ~^b ^ bad_parity, b, 1'b0};
    for (int k = 0; k < 11; k++) begin
      rx = f[k];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // remote device applies writes and answers reads clean, corrupted or not at all
  task automatic serve_cmd();
    logic [7:0] a;
    logic [7:0] d;
    logic       got;
    integer     m;
    recv_frame(a, got);
    if (got && a[7] == 1'b0) begin
      recv_frame(d, got);
      if (got) regs[a[6:0]] = d;
    end else if (got) begin
      m = $random(seed);
      if (m[1:0] == 2'd0) begin
        chk.expect_read({1'b1, {READ_WIDTH{1'b0}}});
      end else begin
        chk.expect_read({m[1:0] == 2'd1, regs[a[6:0]]});
        repeat ((m[3:2] + 1) * CLKS_PER_BIT) @(negedge clk);
        send_frame(regs[a[6:0]], m[1:0] == 2'd1);
      end
    end
  endtask

  initial begin
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    seed     = 4;
    timeouts = 0;
    for (idx = 0; idx < 128; idx++) begin
      regs[idx] = 8'((idx * 5) ^ 8'hA7);
    end
    idx = 0;
    while (rst_n !== 1'b1 && idx < 20) begin
      @(posedge clk);
      idx++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout at %0t: reset was never released", $time);
      timeouts++;
    end
    @(negedge clk);
    repeat (NUM_CMDS) begin
      r = $random(seed);
      // low addresses only, so reads often land on written registers
      cmd = {r[15], 3'b000, r[11:0]};
      r = $random(seed);
      repeat (r[1:0]) @(negedge clk);
      wait_cmd_rdy();
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      if (uart_cmd_pkg::op_e'(cmd[uart_cmd_pkg::rw_bit]) == uart_cmd_pkg::op_write) begin
        chk.expect_frame({1'b0, cmd[uart_cmd_pkg::addr_msb:uart_cmd_pkg::addr_lsb]});
        chk.expect_frame(cmd[7:0]);
      end else begin
        chk.expect_frame({1'b1, cmd[uart_cmd_pkg::addr_msb:uart_cmd_pkg::addr_lsb]});
      end
      fork
        begin
          // vld stays up a few cycles while cmd_rdy is low
          repeat (1 + r[3:2]) @(negedge clk);
          cmd_vld = 1'b0;
        end
        serve_cmd();
      join
    end
    wait_cmd_rdy();
    repeat (4) @(negedge clk);
    chk.final_check(NUM_CMDS);
    $display("frames %0d, reads %0d, errors %0d, timeouts %0d",
             chk.frames, chk.reads, chk.errors, timeouts);
    if (chk.errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/uart_frame_pkg.sv
hw/uart_cmd_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_seq.sv
hw/uart_cmd_bridge.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
